// File: compile.f
source/mem_pkg.sv
source/bus_pkg.sv
source/mem_bus_if.sv
source/lsu_format.sv
source/mem_handler.sv
source/axil_master.sv
source/mem_subsystem.sv
dv/axil_master_assert.sv
dv/tb_mem_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_mem_subsystem
FLAGS ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f compile.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: dv/tb_mem_subsystem.sv
module tb_mem_subsystem import mem_pkg::*, bus_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_W      = 32;
    localparam int RSV_IDX     = 8'hFC;  // word 0x3F0 answers SLVERR
    localparam int NUM_OPS     = 160;
    localparam int CYC_PER_OP  = 40;     // fetch and data access, both fully stalled
    localparam int WATCHDOG_NS = (NUM_OPS * CYC_PER_OP + 20) * 8;

    logic clk;
    logic nrst;
    logic [ADDR_W-1:0] pc_i;
    logic mem_read_i;
    logic mem_write_i;
    logic mem_source_i;
    mem_op_e mem_op_i;
    logic [ADDR_W-1:0] alu_addr_i;
    logic [31:0] reg_data_i;
    logic [31:0] fpu_data_i;
    logic [31:0] instr_o;
    logic instr_valid_o;
    logic [31:0] reg_data_o;
    logic reg_we_o;
    logic freeze_o;
    logic bus_err_o;
    logic [ADDR_W-1:0] awaddr;
    logic awvalid;
    logic awready = 1'b0;
    logic [31:0] wdata;
    logic [3:0] wstrb;
    logic wvalid;
    logic wready = 1'b0;
    logic [1:0] bresp = 2'b00;
    logic bvalid = 1'b0;
    logic bready;
    logic [ADDR_W-1:0] araddr;
    logic arvalid;
    logic arready = 1'b0;
    logic [31:0] rdata = '0;
    logic [1:0] rresp = 2'b00;
    logic rvalid = 1'b0;
    logic rready;

    logic [31:0] mem [0:255];      // slave memory
    logic [31:0] ref_mem [0:255];  // expected memory contents
    logic [31:0] exp_instr[$];
    logic [31:0] exp_load[$];
    int exp_ar = 0;
    int exp_aw = 0;
    int act_ar = 0;
    int act_aw = 0;
    int exp_err = 0;
    int act_err = 0;
    int checks = 0;
    int errors = 0;
    int aw_wait = 0;
    int w_wait = 0;
    int ar_wait = 0;
    int b_wait = 0;
    int r_wait = 0;
    logic got_aw = 1'b0;
    logic got_w = 1'b0;
    logic rd_pend = 1'b0;
    logic resp_taken = 1'b0;  // B or R handshake on the last edge
    logic [31:0] wr_addr = '0;
    logic [31:0] wr_data = '0;
    logic [3:0] wr_strb = '0;
    logic [31:0] rd_addr = '0;

    mem_subsystem #(.ADDR_W(ADDR_W)) dut_i (
        .clk(clk), .nrst(nrst), .pc_i(pc_i), .mem_read_i(mem_read_i),
        .mem_write_i(mem_write_i), .mem_source_i(mem_source_i), .mem_op_i(mem_op_i),
        .alu_addr_i(alu_addr_i), .reg_data_i(reg_data_i), .fpu_data_i(fpu_data_i),
        .instr_o(instr_o), .instr_valid_o(instr_valid_o), .reg_data_o(reg_data_o),
        .reg_we_o(reg_we_o), .freeze_o(freeze_o), .bus_err_o(bus_err_o),
        .m_axi_awaddr_o(awaddr), .m_axi_awvalid_o(awvalid), .m_axi_awready_i(awready),
        .m_axi_wdata_o(wdata), .m_axi_wstrb_o(wstrb), .m_axi_wvalid_o(wvalid),
        .m_axi_wready_i(wready), .m_axi_bresp_i(bresp), .m_axi_bvalid_i(bvalid),
        .m_axi_bready_o(bready), .m_axi_araddr_o(araddr), .m_axi_arvalid_o(arvalid),
        .m_axi_arready_i(arready), .m_axi_rdata_i(rdata), .m_axi_rresp_i(rresp),
        .m_axi_rvalid_i(rvalid), .m_axi_rready_o(rready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] fill_word(input int idx);
        return (idx * 32'h9E37_79B1) ^ {idx[7:0], 24'hA5C3_1E} ^ (idx << 13);
    endfunction

    function automatic logic is_load(input logic [3:0] op);
        return (op >= 4'd1) && (op <= 4'd5);
    endfunction

    function automatic logic is_store(input logic [3:0] op);
        return (op >= 4'd6) && (op <= 4'd8);
    endfunction

    // expected reg_data_o for a load of word at byte offset lo
    function automatic logic [31:0] load_ref(input logic [31:0] word, input logic [3:0] op,
                                             input logic [1:0] lo);
        logic [7:0]  b;
        logic [15:0] h;
        b = word >> (8 * lo);
        h = word >> (16 * lo[1]);  // halfword ignores bit 0
        case (op)
            4'd1: return {{24{b[7]}}, b};
            4'd2: return {{16{h[15]}}, h};
            4'd3: return word;
            4'd4: return {24'd0, b};
            4'd5: return {16'd0, h};
            default: return 32'd0;
        endcase
    endfunction

    // memory word after a store merged into old
    function automatic logic [31:0] store_ref(input logic [31:0] old, input logic [3:0] op,
                                              input logic [1:0] lo, input logic [31:0] data);
        mem_word_u w;
        w.word = old;
        case (op)
            4'd6: w.lane[lo] = data[7:0];
            4'd7: begin
                w.lane[{lo[1], 1'b0}] = data[7:0];
                w.lane[{lo[1], 1'b1}] = data[15:8];
            end
            4'd8: w.word = data;
            default: w.word = old;
        endcase
        return w.word;
    endfunction

    function automatic logic [31:0] code_addr();
        return ($urandom % 128) << 2;
    endfunction

    function automatic logic [31:0] data_addr();
        return 32'h200 + (($urandom % 124) << 2);
    endfunction

    task automatic report_value(input string sig, input logic [31:0] exp, input logic [31:0] got);
        $display("FAILED at %0t: %s expected %08h got %08h", $time, sig, exp, got);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    // AXI4-Lite slave with random ready and response delays
    always @(posedge clk) begin
        if (!nrst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            got_aw  <= 1'b0;
            got_w   <= 1'b0;
            rd_pend <= 1'b0;
            aw_wait <= $urandom % 5;
            w_wait  <= $urandom % 5;
            ar_wait <= $urandom % 5;
            b_wait  <= $urandom % 5;
            r_wait  <= $urandom % 5;
        end else begin
            if (awready) begin  // valid is held, so this is a handshake
                awready <= 1'b0;
                got_aw  <= 1'b1;
                wr_addr <= awaddr;
                act_aw  <= act_aw + 1;
                aw_wait <= $urandom % 5;
            end else if (awvalid && !got_aw) begin
                if (aw_wait == 0) awready <= 1'b1;
                else aw_wait <= aw_wait - 1;
            end
            if (wready) begin
                wready  <= 1'b0;
                got_w   <= 1'b1;
                wr_data <= wdata;
                wr_strb <= wstrb;
                w_wait  <= $urandom % 5;
            end else if (wvalid && !got_w) begin
                if (w_wait == 0) wready <= 1'b1;
                else w_wait <= w_wait - 1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                b_wait <= $urandom % 5;
            end else if (got_aw && got_w && !bvalid) begin
                if (b_wait == 0) begin
                    for (int i = 0; i < 4; i++) begin
                        if (wr_strb[i]) mem[wr_addr[9:2]][8*i +: 8] <= wr_data[8*i +: 8];
                    end
                    bresp  <= OKAY;
                    bvalid <= 1'b1;
                    got_aw <= 1'b0;
                    got_w  <= 1'b0;
                end else begin
                    b_wait <= b_wait - 1;
                end
            end
            if (arready) begin
                arready <= 1'b0;
                rd_pend <= 1'b1;
                rd_addr <= araddr;
                act_ar  <= act_ar + 1;
                ar_wait <= $urandom % 5;
            end else if (arvalid && !rd_pend) begin
                if (ar_wait == 0) arready <= 1'b1;
                else ar_wait <= ar_wait - 1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                r_wait <= $urandom % 5;
            end else if (rd_pend && !rvalid) begin
                if (r_wait == 0) begin
                    rdata   <= mem[rd_addr[9:2]];
                    rresp   <= (int'(rd_addr[9:2]) == RSV_IDX) ? SLVERR : OKAY;
                    rvalid  <= 1'b1;
                    rd_pend <= 1'b0;
                end else begin
                    r_wait <= r_wait - 1;
                end
            end
        end
    end

    // compare process for every completion event
    always @(posedge clk) begin
        if (nrst) begin
            if (instr_valid_o) begin
                if (exp_instr.size() == 0) begin
                    report_error("instruction returned with none expected");
                end else begin
                    logic [31:0] e;
                    e = exp_instr.pop_front();
                    checks++;
                    assert (instr_o == e) else report_value("instr_o", e, instr_o);
                end
            end
            if (reg_we_o) begin
                if (exp_load.size() == 0) begin
                    report_error("reg_we_o pulsed with no load pending");
                end else begin
                    logic [31:0] e;
                    e = exp_load.pop_front();
                    checks++;
                    assert (reg_data_o == e) else report_value("reg_data_o", e, reg_data_o);
                end
            end
            if (bus_err_o) act_err++;
            // bus activity, the done cycle and DATA all lie inside one instruction
            if (awvalid || wvalid || arvalid || bready || rready || resp_taken ||
                instr_valid_o) begin
                assert (freeze_o) else report_value("freeze_o", 32'd1, {31'd0, freeze_o});
            end
            resp_taken <= (bvalid && bready) || (rvalid && rready);
        end
    end

    // one instruction: data op now, then fetch of pc
    task automatic step(input logic [31:0] pc, input logic rd, input logic wr, input logic src,
                        input logic [3:0] op, input logic [31:0] addr,
                        input logic [31:0] rdat, input logic [31:0] fdat);
        int idx;
        do @(posedge clk); while (freeze_o || !nrst);  // wait for FETCH
        checks++;
        assert (act_ar == exp_ar && act_aw == exp_aw)
            else report_error("number of AXI transactions differs from the expected count");
        pc_i         <= pc;
        mem_read_i   <= rd;
        mem_write_i  <= wr;
        mem_source_i <= src;
        mem_op_i     <= mem_op_e'(op);
        alu_addr_i   <= addr;
        reg_data_i   <= rdat;
        fpu_data_i   <= fdat;
        idx = addr[9:2];
        exp_ar++;  // fetch of the previous pc starts now
        if (rd && is_load(op)) begin
            exp_ar++;
            if (idx == RSV_IDX) exp_err++;
            else exp_load.push_back(load_ref(ref_mem[idx], op, addr[1:0]));
        end
        if (wr && is_store(op)) begin
            exp_aw++;
            ref_mem[idx] = store_ref(ref_mem[idx], op, addr[1:0], src ? fdat : rdat);
        end
        exp_instr.push_back(ref_mem[pc[9:2]]);
    endtask

    task automatic nop();
        step(code_addr(), 1'b0, 1'b0, 1'b0, 4'd0, '0, '0, '0);
    endtask

    task automatic end_test(input string name, input int errs_before, input int checks_before);
        nop();
        nop();
        checks++;
        assert (exp_err == act_err) else report_error("bus_err_o pulse count is wrong");
        checks++;
        assert (exp_load.size() == 0) else report_error("a load never wrote back");
        $display("test %s: %0d checks, %0d errors", name, checks - checks_before,
                 errors - errs_before);
    endtask

    initial begin
        int e0;
        int c0;
        logic [31:0] a;
        void'($urandom(32'he891b5b5));
        nrst = 1'b0;
        pc_i = '0;
        mem_read_i = 1'b0;
        mem_write_i = 1'b0;
        mem_source_i = 1'b0;
        mem_op_i = OP_NONE;
        alu_addr_i = '0;
        reg_data_i = '0;
        fpu_data_i = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        exp_instr.push_back(ref_mem[0]);  // first fetch uses pc 0
        repeat (5) @(posedge clk);
        nrst <= 1'b1;

        e0 = errors;
        c0 = checks;
        for (int i = 0; i < 20; i++) begin
            step(code_addr(), 1'($urandom), 1'($urandom), 1'b0, 4'd0, data_addr(), '0, '0);
        end
        end_test("fetch", e0, c0);

        e0 = errors;
        c0 = checks;
        for (int op = 6; op <= 8; op++) begin
            for (int lane = 0; lane < 4; lane++) begin
                for (int src = 0; src < 2; src++) begin
                    a = data_addr() + lane;
                    step(code_addr(), 1'b0, 1'b1, 1'(src), 4'(op), a, $urandom, $urandom);
                    step(code_addr(), 1'b1, 1'b0, 1'b0, 4'd3, a, '0, '0);
                end
            end
        end
        end_test("stores", e0, c0);

        e0 = errors;
        c0 = checks;
        for (int op = 1; op <= 5; op++) begin
            for (int lane = 0; lane < 4; lane++) begin
                step(code_addr(), 1'b1, 1'b0, 1'b0, 4'(op), data_addr() + lane, '0, '0);
            end
        end
        end_test("loads", e0, c0);

        e0 = errors;
        c0 = checks;
        for (int op = 9; op <= 15; op++) begin
            step(code_addr(), 1'b1, 1'b1, 1'b0, 4'(op), data_addr(), $urandom, $urandom);
        end
        end_test("invalid ops", e0, c0);

        e0 = errors;
        c0 = checks;
        step(code_addr(), 1'b1, 1'b0, 1'b0, 4'd3, RSV_IDX << 2, '0, '0);
        for (int i = 0; i < 3; i++) begin
            step(code_addr(), 1'b1, 1'b0, 1'b0, 4'(1 + $urandom % 5), data_addr(), '0, '0);
        end
        end_test("error response", e0, c0);

        e0 = errors;
        c0 = checks;
        for (int i = 0; i < 30; i++) begin
            logic [3:0] op;
            op = 4'($urandom % 9);
            step(code_addr(), is_load(op), is_store(op), 1'($urandom), op,
                 data_addr() + ($urandom % 4), $urandom, $urandom);
        end
        end_test("back-pressure", e0, c0);

        $display("done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog sized for every operation stalled at the worst delays
    initial begin
        #(WATCHDOG_NS * 1ns);
        $display("ERROR: run did not finish within %0d ns", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: dv/axil_master_assert.sv
module axil_master_assert (
    input logic clk,
    input logic nrst,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready,
    input logic arvalid,
    input logic arready,
    input logic bready,
    input logic rready,
    input logic req,
    input logic done
);
    timeunit 1ns;
    timeprecision 1ps;

    // a valid may only drop on its own handshake
    aw_held: assert property (@(posedge clk) disable iff (!nrst)
        awvalid && !awready |=> awvalid) else $error("AWVALID dropped before AWREADY");
    w_held: assert property (@(posedge clk) disable iff (!nrst)
        wvalid && !wready |=> wvalid) else $error("WVALID dropped before WREADY");
    ar_held: assert property (@(posedge clk) disable iff (!nrst)
        arvalid && !arready |=> arvalid) else $error("ARVALID dropped before ARREADY");

    // one access at a time, read or write
    no_rd_wr: assert property (@(posedge clk) disable iff (!nrst)
        !(arvalid && awvalid)) else $error("ARVALID and AWVALID high together");

    done_pulse: assert property (@(posedge clk) disable iff (!nrst)
        done |=> !done) else $error("done high for two cycles");

    // anything on the bus or done means an access is still open
    req_idle: assert property (@(posedge clk) disable iff (!nrst)
        req |-> !(awvalid || wvalid || arvalid || bready || rready || done))
        else $error("req issued while an access is pending");

endmodule

bind axil_master axil_master_assert u_axil_master_assert (
    .clk     (clk),
    .nrst    (nrst),
    .awvalid (m_axi_awvalid_o),
    .awready (m_axi_awready_i),
    .wvalid  (m_axi_wvalid_o),
    .wready  (m_axi_wready_i),
    .arvalid (m_axi_arvalid_o),
    .arready (m_axi_arready_i),
    .bready  (m_axi_bready_o),
    .rready  (m_axi_rready_o),
    .req     (bus_i.req),
    .done    (bus_i.done)
);

// File: source/mem_subsystem.sv
module mem_subsystem import mem_pkg::*, bus_pkg::*; #(
    parameter int ADDR_W = 32
) (
    input  logic              clk,
    input  logic              nrst,
    // core side
    input  logic [ADDR_W-1:0] pc_i,
    input  logic              mem_read_i,
    input  logic              mem_write_i,
    input  logic              mem_source_i,
    input  mem_op_e           mem_op_i,
    input  logic [ADDR_W-1:0] alu_addr_i,
    input  logic [31:0]       reg_data_i,
    input  logic [31:0]       fpu_data_i,
    output logic [31:0]       instr_o,
    output logic              instr_valid_o,
    output logic [31:0]       reg_data_o,
    output logic              reg_we_o,
    output logic              freeze_o,
    output logic              bus_err_o,
    // AXI4-Lite master
    output logic [ADDR_W-1:0] m_axi_awaddr_o,
    output logic              m_axi_awvalid_o,
    input  logic              m_axi_awready_i,
    output logic [DATA_W-1:0] m_axi_wdata_o,
    output logic [STRB_W-1:0] m_axi_wstrb_o,
    output logic              m_axi_wvalid_o,
    input  logic              m_axi_wready_i,
    input  logic [1:0]        m_axi_bresp_i,
    input  logic              m_axi_bvalid_i,
    output logic              m_axi_bready_o,
    output logic [ADDR_W-1:0] m_axi_araddr_o,
    output logic              m_axi_arvalid_o,
    input  logic              m_axi_arready_i,
    input  logic [DATA_W-1:0] m_axi_rdata_i,
    input  logic [1:0]        m_axi_rresp_i,
    input  logic              m_axi_rvalid_i,
    output logic              m_axi_rready_o
);
    mem_bus_if #(.ADDR_W(ADDR_W)) mem_bus ();

    mem_handler #(.ADDR_W(ADDR_W)) u_mem_handler (
        .clk           (clk),
        .nrst          (nrst),
        .pc_i          (pc_i),
        .mem_read_i    (mem_read_i),
        .mem_write_i   (mem_write_i),
        .mem_source_i  (mem_source_i),
        .mem_op_i      (mem_op_i),
        .alu_addr_i    (alu_addr_i),
        .reg_data_i    (reg_data_i),
        .fpu_data_i    (fpu_data_i),
        .instr_o       (instr_o),
        .instr_valid_o (instr_valid_o),
        .reg_data_o    (reg_data_o),
        .reg_we_o      (reg_we_o),
        .freeze_o      (freeze_o),
        .bus_err_o     (bus_err_o),
        .bus_o         (mem_bus.requester)
    );

    axil_master #(.ADDR_W(ADDR_W)) u_axil_master (
        .clk             (clk),
        .nrst            (nrst),
        .bus_i           (mem_bus.bridge),
        .m_axi_awaddr_o  (m_axi_awaddr_o),
        .m_axi_awvalid_o (m_axi_awvalid_o),
        .m_axi_awready_i (m_axi_awready_i),
        .m_axi_wdata_o   (m_axi_wdata_o),
        .m_axi_wstrb_o   (m_axi_wstrb_o),
        .m_axi_wvalid_o  (m_axi_wvalid_o),
        .m_axi_wready_i  (m_axi_wready_i),
        .m_axi_bresp_i   (m_axi_bresp_i),
        .m_axi_bvalid_i  (m_axi_bvalid_i),
        .m_axi_bready_o  (m_axi_bready_o),
        .m_axi_araddr_o  (m_axi_araddr_o),
        .m_axi_arvalid_o (m_axi_arvalid_o),
        .m_axi_arready_i (m_axi_arready_i),
        .m_axi_rdata_i   (m_axi_rdata_i),
        .m_axi_rresp_i   (m_axi_rresp_i),
        .m_axi_rvalid_i  (m_axi_rvalid_i),
        .m_axi_rready_o  (m_axi_rready_o)
    );

endmodule

// File: source/axil_master.sv
module axil_master import bus_pkg::*; #(
    parameter int ADDR_W = 32
) (
    input  logic              clk,
    input  logic              nrst,
    mem_bus_if.bridge         bus_i,
    output logic [ADDR_W-1:0] m_axi_awaddr_o,
    output logic              m_axi_awvalid_o,
    input  logic              m_axi_awready_i,
    output logic [DATA_W-1:0] m_axi_wdata_o,
    output logic [STRB_W-1:0] m_axi_wstrb_o,
    output logic              m_axi_wvalid_o,
    input  logic              m_axi_wready_i,
    input  logic [1:0]        m_axi_bresp_i,
    input  logic              m_axi_bvalid_i,
    output logic              m_axi_bready_o,
    output logic [ADDR_W-1:0] m_axi_araddr_o,
    output logic              m_axi_arvalid_o,
    input  logic              m_axi_arready_i,
    input  logic [DATA_W-1:0] m_axi_rdata_i,
    input  logic [1:0]        m_axi_rresp_i,
    input  logic              m_axi_rvalid_i,
    output logic              m_axi_rready_o
);
    typedef enum logic [1:0] {
        M_IDLE,
        M_XFER,   // address and write data out
        M_RESP,   // waiting on B or R
        M_DONE
    } mst_state_e;

    mst_state_e        state;
    logic              we_q;
    logic              aw_done;     // AW accepted
    logic              w_done;      // W accepted
    logic              err_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [STRB_W-1:0] wstrb_q;
    logic [DATA_W-1:0] rdata_q;
    logic              aw_hs;
    logic              w_hs;
    logic              b_hs;
    logic              ar_hs;
    logic              r_hs;

    function automatic logic resp_is_err(input logic [1:0] resp);
        return (resp == SLVERR) || (resp == DECERR);
    endfunction

    assign m_axi_awvalid_o = (state == M_XFER) && we_q && !aw_done;
    assign m_axi_wvalid_o  = (state == M_XFER) && we_q && !w_done;
    assign m_axi_arvalid_o = (state == M_XFER) && !we_q;
    assign m_axi_bready_o  = (state == M_RESP) && we_q;
    assign m_axi_rready_o  = (state == M_RESP) && !we_q;

    assign m_axi_awaddr_o = addr_q;
    assign m_axi_araddr_o = addr_q;
    assign m_axi_wdata_o  = wdata_q;
    assign m_axi_wstrb_o  = wstrb_q;

    assign aw_hs = m_axi_awvalid_o && m_axi_awready_i;
    assign w_hs  = m_axi_wvalid_o && m_axi_wready_i;
    assign b_hs  = m_axi_bready_o && m_axi_bvalid_i;
    assign ar_hs = m_axi_arvalid_o && m_axi_arready_i;
    assign r_hs  = m_axi_rready_o && m_axi_rvalid_i;

    assign bus_i.done  = (state == M_DONE);
    assign bus_i.rdata = rdata_q;
    assign bus_i.err   = err_q;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state   <= M_IDLE;
            we_q    <= 1'b0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            case (state)
                M_IDLE: begin
                    if (bus_i.req) begin
                        we_q    <= bus_i.we;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        state   <= M_XFER;
                    end
                end
                M_XFER: begin
                    if (we_q) begin
                        aw_done <= aw_done | aw_hs;
                        w_done  <= w_done | w_hs;
                        if ((aw_done || aw_hs) && (w_done || w_hs)) begin
                            state <= M_RESP;  // both channels taken, in any order
                        end
                    end else if (ar_hs) begin
                        state <= M_RESP;
                    end
                end
                M_RESP: begin
                    if (b_hs) begin
                        err_q <= resp_is_err(m_axi_bresp_i);
                        state <= M_DONE;
                    end else if (r_hs) begin
                        err_q <= resp_is_err(m_axi_rresp_i);
                        state <= M_DONE;
                    end
                end
                default: state <= M_IDLE;  // done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == M_IDLE) && bus_i.req) begin
            addr_q  <= bus_i.addr;
            wdata_q <= bus_i.wdata;
            wstrb_q <= bus_i.wstrb;
        end
        if (r_hs) begin
            rdata_q <= m_axi_rdata_i;
        end
    end

endmodule

// File: source/mem_handler.sv
module mem_handler import mem_pkg::*; #(
    parameter int ADDR_W = 32
) (
    input  logic              clk,
    input  logic              nrst,
    input  logic [ADDR_W-1:0] pc_i,
    input  logic              mem_read_i,
    input  logic              mem_write_i,
    input  logic              mem_source_i,   // 1 stores from the fpu file
    input  mem_op_e           mem_op_i,
    input  logic [ADDR_W-1:0] alu_addr_i,
    input  logic [31:0]       reg_data_i,
    input  logic [31:0]       fpu_data_i,
    output logic [31:0]       instr_o,
    output logic              instr_valid_o,
    output logic [31:0]       reg_data_o,
    output logic              reg_we_o,
    output logic              freeze_o,
    output logic              bus_err_o,
    mem_bus_if.requester      bus_o
);
    phase_e      phase;
    phase_e      phase_n;
    logic        pend_load;       // data access in flight is a load
    logic [31:0] store_data;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic [31:0] load_data;
    logic        op_is_load;
    logic        op_is_store;
    logic        load_go;
    logic        store_go;

    assign store_data = mem_source_i ? fpu_data_i : reg_data_i;

    // core inputs are held while frozen, so the same decode serves D_WAIT
    lsu_format u_lsu_format (
        .op_i          (mem_op_i),
        .addr_lo_i     (alu_addr_i[1:0]),
        .store_data_i  (store_data),
        .load_word_i   (bus_o.rdata),
        .wdata_o       (wdata),
        .wstrb_o       (wstrb),
        .load_data_o   (load_data),
        .op_is_load_o  (op_is_load),
        .op_is_store_o (op_is_store)
    );

    assign load_go  = mem_read_i & op_is_load;
    assign store_go = mem_write_i & op_is_store;

    assign bus_o.wdata = wdata;
    assign bus_o.wstrb = wstrb;

    // core only runs during the fetch cycle
    assign freeze_o = (phase != FETCH);

    always_comb begin
        phase_n    = phase;
        bus_o.req  = 1'b0;
        bus_o.we   = 1'b0;
        bus_o.addr = pc_i;  // fetch address by default
        case (phase)
            FETCH: begin
                bus_o.req = 1'b1;
                phase_n   = F_WAIT;
            end
            F_WAIT: begin
                if (bus_o.done) begin
                    phase_n = DATA;  // even on a fetch error
                end
            end
            DATA: begin
                bus_o.addr = alu_addr_i;
                if (load_go || store_go) begin
                    bus_o.req = 1'b1;
                    bus_o.we  = store_go;
                    phase_n   = D_WAIT;
                end else begin
                    phase_n = FETCH;  // no data access
                end
            end
            D_WAIT: begin
                if (bus_o.done) begin
                    phase_n = FETCH;
                end
            end
            default: phase_n = FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            phase         <= FETCH;
            pend_load     <= 1'b0;
            instr_valid_o <= 1'b0;
            reg_we_o      <= 1'b0;
            bus_err_o     <= 1'b0;
        end else begin
            phase         <= phase_n;
            instr_valid_o <= (phase == F_WAIT) && bus_o.done;
            reg_we_o      <= (phase == D_WAIT) && bus_o.done && pend_load && !bus_o.err;
            bus_err_o     <= bus_o.done && bus_o.err;
            if (phase == DATA) begin
                pend_load <= load_go;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((phase == F_WAIT) && bus_o.done) begin
            instr_o <= bus_o.rdata;
        end
        if ((phase == D_WAIT) && bus_o.done && pend_load) begin
            reg_data_o <= load_data;  // extended value
        end
    end

endmodule

// File: source/lsu_format.sv
module lsu_format import mem_pkg::*; (
    input  mem_op_e     op_i,
    input  logic [1:0]  addr_lo_i,     // byte offset within the word
    input  logic [31:0] store_data_i,
    input  logic [31:0] load_word_i,   // raw word from the bus
    output logic [31:0] wdata_o,
    output logic [3:0]  wstrb_o,
    output logic [31:0] load_data_o,
    output logic        op_is_load_o,
    output logic        op_is_store_o
);
    mem_word_u  st_src;
    mem_word_u  st_word;
    mem_word_u  ld_word;
    logic [7:0] ld_byte;
    logic [15:0] ld_half;

    assign st_src.word  = store_data_i;
    assign ld_word.word = load_word_i;

    // a halfword ignores bit 0 of the offset
    assign ld_byte = ld_word.lane[addr_lo_i];
    assign ld_half = {ld_word.lane[{addr_lo_i[1], 1'b1}], ld_word.lane[{addr_lo_i[1], 1'b0}]};

    always_comb begin
        st_word.word  = '0;
        wstrb_o       = '0;
        load_data_o   = '0;
        op_is_load_o  = 1'b0;
        op_is_store_o = 1'b0;
        case (op_i)
            OP_LB: begin
                op_is_load_o = 1'b1;
                load_data_o  = {{24{ld_byte[7]}}, ld_byte};
            end
            OP_LH: begin
                op_is_load_o = 1'b1;
                load_data_o  = {{16{ld_half[15]}}, ld_half};
            end
            OP_LW: begin
                op_is_load_o = 1'b1;
                load_data_o  = ld_word.word;  // offset ignored
            end
            OP_LBU: begin
                op_is_load_o = 1'b1;
                load_data_o  = {24'd0, ld_byte};
            end
            OP_LHU: begin
                op_is_load_o = 1'b1;
                load_data_o  = {16'd0, ld_half};
            end
            OP_SB: begin
                op_is_store_o              = 1'b1;
                st_word.lane[addr_lo_i]    = st_src.lane[0];
                wstrb_o[addr_lo_i]         = 1'b1;
            end
            OP_SH: begin
                op_is_store_o                          = 1'b1;
                st_word.lane[{addr_lo_i[1], 1'b0}]     = st_src.lane[0];
                st_word.lane[{addr_lo_i[1], 1'b1}]     = st_src.lane[1];
                wstrb_o = addr_lo_i[1] ? 4'b1100 : 4'b0011;
            end
            OP_SW: begin
                op_is_store_o = 1'b1;
                st_word       = st_src;
                wstrb_o       = 4'b1111;
            end
            default: begin
                // none and invalid codes: no access at all
            end
        endcase
    end

    assign wdata_o = st_word.word;

endmodule

// File: source/mem_bus_if.sv
interface mem_bus_if import bus_pkg::*; #(
    parameter int ADDR_W = 32
);
    logic              req;    // one cycle, only when nothing pending
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic [DATA_W-1:0] rdata;  // valid with done
    logic              done;   // one cycle, ends the access
    logic              err;    // valid with done

    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        output wstrb,
        input  rdata,
        input  done,
        input  err
    );

    modport bridge (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        input  wstrb,
        output rdata,
        output done,
        output err
    );

endinterface

// File: source/bus_pkg.sv
package bus_pkg;

    // AXI4-Lite data path width
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;  // one strobe per byte

    // BRESP / RRESP encodings
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

endpackage

// File: source/mem_pkg.sv
package mem_pkg;

    // memory op codes as decoded by the control unit
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_LB   = 4'd1,  // load byte, sign extended
        OP_LH   = 4'd2,  // load half, sign extended
        OP_LW   = 4'd3,
        OP_LBU  = 4'd4,  // load byte, zero extended
        OP_LHU  = 4'd5,  // load half, zero extended
        OP_SB   = 4'd6,
        OP_SH   = 4'd7,
        OP_SW   = 4'd8   // 9..15 are invalid
    } mem_op_e;

    // one instruction walks through these in order
    typedef enum logic [1:0] {
        FETCH  = 2'd0,
        F_WAIT = 2'd1,
        DATA   = 2'd2,
        D_WAIT = 2'd3
    } phase_e;

    // one bus word, seen whole or as four byte lanes
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] lane;  // lane 0 is the lowest address
    } mem_word_u;

endpackage
